// ==== carrierLoop.f ====
rtl/carrierLoopPkg.sv
rtl/loopRegs.sv
rtl/errorSelect.sv
rtl/loopFilter.sv
rtl/lockDetector.sv
rtl/carrierLoop.sv
testbench/carrierLoopTb.sv

// ==== rtl/carrierLoop.sv ====
`timescale 1ns/10ps

module carrierLoop
    import carrierLoopPkg::*;
#(
    parameter logic [11:0] regBase = 12'h100
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [11:0] addr,
    input  logic [31:0] din,
    input  logic        wr0,
    input  logic        wr1,
    input  logic        wr2,
    input  logic        wr3,
    input  demodModeT   demodMode,
    input  logic        ddcSync,
    input  logic        resampSync,
    input  logic [11:0] phase,
    input  logic [11:0] freq,
    input  logic        highFreqOffset,
    input  logic [11:0] offsetError,
    input  logic        offsetErrorEn,
    output logic [31:0] dout,
    output logic [31:0] carrierFreqOffset,
    output logic [31:0] carrierLeadFreq,
    output logic        carrierFreqEn,
    output logic [11:0] loopError,
    output logic        carrierLock,
    output logic [15:0] lockCounter
);

    loopCtrlT    ctrl;
    loopOutT     loopOut;
    logic [31:0] lagAccumTop;
    logic        loopFilterEn;
    logic [11:0] modeError;
    logic        enableLock;

    loopRegs #(
        .regBase(regBase)
    ) regs (
        .clk(clk), .reset(reset),
        .addr(addr), .din(din),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .lagAccumTop(lagAccumTop),
        .dout(dout),
        .ctrl(ctrl)
    );

    errorSelect errSel (
        .clk(clk),
        .demodMode(demodMode),
        .ddcSync(ddcSync), .resampSync(resampSync),
        .phase(phase), .freq(freq),
        .offsetError(offsetError), .offsetErrorEn(offsetErrorEn),
        .highFreqOffset(highFreqOffset),
        .ctrl(ctrl),
        .loopFilterEn(loopFilterEn),
        .loopError(loopError),
        .modeError(modeError),
        .enableLock(enableLock)
    );

    loopFilter filter (
        .clk(clk), .reset(reset),
        .loopFilterEn(loopFilterEn),
        .loopError(loopError),
        .highFreqOffset(highFreqOffset),
        .carrierLock(carrierLock),
        .ctrl(ctrl),
        .loopOut(loopOut),
        .lagAccumTop(lagAccumTop)
    );

    lockDetector lockDet (
        .clk(clk), .reset(reset),
        .loopFilterEn(loopFilterEn),
        .modeError(modeError),
        .enableLock(enableLock),
        .ctrl(ctrl),
        .carrierLock(carrierLock),
        .lockCounter(lockCounter)
    );

    assign carrierFreqOffset = loopOut.freqOffset;
    assign carrierLeadFreq   = loopOut.leadFreq;
    assign carrierFreqEn     = loopOut.freqEn;

endmodule

// ==== rtl/carrierLoopPkg.sv ====
package carrierLoopPkg;

    ///////////////////////////////////////////////////////////////////////
    // Loop constants
    ///////////////////////////////////////////////////////////////////////

    // Width of the lead and lag accumulators, top 32 bits are the output.
    localparam int accumWidth = 40;

    ///////////////////////////////////////////////////////////////////////
    // Encodings
    ///////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        modeAm         = 4'd0,
        modePm         = 4'd1,
        modeFm         = 4'd2,
        modePcmTrellis = 4'd3,
        modeMultiH     = 4'd4,
        mode2Fsk       = 4'd5,
        modeBpsk       = 4'd6,
        modeQpsk       = 4'd7,
        modeOqpsk      = 4'd8,
        modeSoqpsk     = 4'd9,
        modeAuqpsk     = 4'd10
    } demodModeT;

    // Byte offsets of the words inside the loop register space.
    typedef enum logic [4:0] {
        regControl   = 5'd0,
        regGains     = 5'd4,
        regLimit     = 5'd8,
        regSweepRate = 5'd12,
        regLock      = 5'd16,
        regLagAccum  = 5'd20
    } regOffsetT;

    ///////////////////////////////////////////////////////////////////////
    // Bundles
    ///////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        invertError;
        logic        zeroError;
        logic        sweepEnable;
        logic        clearAccum;
        logic [4:0]  leadExp;
        logic [4:0]  lagExp;
        logic [31:0] limit;
        logic [31:0] sweepRate;
        logic [15:0] lockCount;
        logic [11:0] syncThreshold;
    } loopCtrlT;

    typedef struct packed {
        logic [31:0] freqOffset;
        logic [31:0] leadFreq;
        logic        freqEn;
    } loopOutT;

endpackage

// ==== rtl/errorSelect.sv ====
`timescale 1ns/10ps

module errorSelect
    import carrierLoopPkg::*;
(
    input  logic        clk,
    input  demodModeT   demodMode,
    input  logic        ddcSync,
    input  logic        resampSync,
    input  logic [11:0] phase,
    input  logic [11:0] freq,
    input  logic [11:0] offsetError,
    input  logic        offsetErrorEn,
    input  logic        highFreqOffset,
    input  loopCtrlT    ctrl,
    output logic        loopFilterEn,
    output logic [11:0] loopError,
    output logic [11:0] modeError,
    output logic        enableLock
);

    logic        sync;
    logic        modeErrorEn;
    logic [11:0] qpskPhase;
    logic        breakLoop;

    // Rotate the QPSK constellation so the decision point sits at zero.
    assign qpskPhase = phase - 12'h200;

    always_comb begin
        sync        = ddcSync;
        modeError   = 12'h0;
        modeErrorEn = 1'b1;
        enableLock  = 1'b1;
        case (demodMode)
            modeAm: begin
                enableLock = 1'b0;
            end
            modePm: begin
                modeError = phase;
            end
            modeFm, modePcmTrellis, modeMultiH: begin
                modeError  = freq;
                enableLock = 1'b0;
            end
            mode2Fsk: begin
                sync        = resampSync;
                modeError   = offsetError;
                modeErrorEn = offsetErrorEn;
                enableLock  = 1'b0;
            end
            modeBpsk: begin
                modeError = {phase[10:0], 1'b1};
            end
            modeQpsk, modeOqpsk, modeSoqpsk, modeAuqpsk: begin
                modeError = {qpskPhase[9:0], 2'b10};
            end
            default: begin
                // Free running, every clock is a strobe.
                sync = 1'b1;
            end
        endcase
    end

    assign loopFilterEn = sync & modeErrorEn;

    // Open the loop while sweeping with a large frequency offset.
    assign breakLoop = ctrl.zeroError || (ctrl.sweepEnable && highFreqOffset);

    always_ff @(posedge clk) begin
        if (loopFilterEn) begin
            if (breakLoop) begin
                loopError <= 12'h0;
            end else if (ctrl.invertError) begin
                loopError <= ~modeError + 12'h1;
            end else begin
                loopError <= modeError;
            end
        end
    end

endmodule

// ==== rtl/lockDetector.sv ====
`timescale 1ns/10ps

module lockDetector
    import carrierLoopPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        loopFilterEn,
    input  logic [11:0] modeError,
    input  logic        enableLock,
    input  loopCtrlT    ctrl,
    output logic        carrierLock,
    output logic [15:0] lockCounter
);

    logic [11:0] absError;
    logic [11:0] absErrorReg;
    logic        errorHigh;

    assign absError = modeError[11] ? (~modeError + 12'h1) : modeError;

    always_ff @(posedge clk) begin
        if (loopFilterEn) begin
            absErrorReg <= absError;
        end
    end

    // Compare the magnitude captured at the previous strobe.
    assign errorHigh = absErrorReg > ctrl.syncThreshold;

    always_ff @(posedge clk) begin
        if (reset || !enableLock) begin
            lockCounter <= 16'h0;
            carrierLock <= 1'b1;
        end else if (loopFilterEn) begin
            if (errorHigh) begin
                // Counting down from zero wraps, so the loss point is 16'hFFFF - lockCount.
                if (lockCounter == (16'hFFFF - ctrl.lockCount)) begin
                    carrierLock <= 1'b0;
                    lockCounter <= 16'h0;
                end else begin
                    lockCounter <= lockCounter - 16'h1;
                end
            end else begin
                if (lockCounter == ctrl.lockCount) begin
                    carrierLock <= 1'b1;
                    lockCounter <= 16'h0;
                end else begin
                    lockCounter <= lockCounter + 16'h1;
                end
            end
        end
    end

endmodule

// ==== rtl/loopFilter.sv ====
`timescale 1ns/10ps

module loopFilter
    import carrierLoopPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        loopFilterEn,
    input  logic [11:0] loopError,
    input  logic        highFreqOffset,
    input  logic        carrierLock,
    input  loopCtrlT    ctrl,
    output loopOutT     loopOut,
    output logic [31:0] lagAccumTop
);

    typedef logic signed [accumWidth-1:0] accumT;

    // Bits below the 32-bit output word.
    localparam int fracBits = accumWidth - 32;

    accumT leadAccum;
    accumT lagAccum;
    logic  sweepUp;

    accumT                     errorExt;
    accumT                     sweepStep;
    accumT                     lagStep;
    logic signed [accumWidth:0] lagSum;
    logic signed [32:0]        sumTop;
    logic signed [32:0]        posLimit;
    logic signed [32:0]        negLimit;
    logic                      sweeping;
    logic                      overPos;
    logic                      underNeg;

    assign errorExt  = {{(accumWidth-12){loopError[11]}}, loopError};
    assign sweepStep = accumT'(ctrl.sweepRate) << fracBits;

    // Sweep only while the carrier is not held in sync.
    assign sweeping = ctrl.sweepEnable && !(carrierLock && !highFreqOffset);

    always_comb begin
        if (sweeping) begin
            lagStep = sweepUp ? sweepStep : -sweepStep;
        end else begin
            lagStep = errorExt <<< ctrl.lagExp;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Clamp, compared in the top word against the limit register
    ///////////////////////////////////////////////////////////////////////

    assign lagSum   = lagAccum + lagStep;
    assign sumTop   = lagSum[accumWidth:fracBits];
    assign posLimit = {1'b0, ctrl.limit};
    assign negLimit = -posLimit;
    assign overPos  = sumTop > posLimit;
    assign underNeg = sumTop < negLimit;

    always_ff @(posedge clk) begin
        if (reset) begin
            leadAccum <= '0;
            lagAccum  <= '0;
            sweepUp   <= 1'b1;
        end else if (loopFilterEn) begin
            leadAccum <= errorExt <<< ctrl.leadExp;
            if (ctrl.clearAccum) begin
                lagAccum <= '0;
            end else if (overPos) begin
                lagAccum <= {ctrl.limit, {fracBits{1'b0}}};
            end else if (underNeg) begin
                lagAccum <= {negLimit[31:0], {fracBits{1'b0}}};
            end else begin
                lagAccum <= lagSum[accumWidth-1:0];
            end
            // Reverse the sweep at either end of the range.
            if (sweeping && !ctrl.clearAccum) begin
                if (overPos) begin
                    sweepUp <= 1'b0;
                end else if (underNeg) begin
                    sweepUp <= 1'b1;
                end
            end
        end
    end

    assign lagAccumTop        = lagAccum[accumWidth-1 -: 32];
    assign loopOut.freqOffset = lagAccum[accumWidth-1 -: 32];
    assign loopOut.leadFreq   = leadAccum[accumWidth-1 -: 32];
    assign loopOut.freqEn     = loopFilterEn;

endmodule

// ==== rtl/loopRegs.sv ====
`timescale 1ns/10ps

module loopRegs
    import carrierLoopPkg::*;
#(
    parameter logic [11:0] regBase = 12'h100
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [11:0] addr,
    input  logic [31:0] din,
    input  logic        wr0,
    input  logic        wr1,
    input  logic        wr2,
    input  logic        wr3,
    input  logic [31:0] lagAccumTop,
    output logic [31:0] dout,
    output loopCtrlT    ctrl
);

    logic       inSpace;
    regOffsetT  offset;
    logic [3:0] byteEn;
    logic       wrEn;
    logic [31:0] regWord;
    logic [31:0] mergedWord;

    function automatic logic [31:0] mergeBytes(
        input logic [31:0] oldWord,
        input logic [31:0] newWord,
        input logic [3:0]  strobes
    );
        logic [31:0] result;
        result = oldWord;
        for (int i = 0; i < 4; i++) begin
            if (strobes[i]) begin
                result[8*i +: 8] = newWord[8*i +: 8];
            end
        end
        return result;
    endfunction

    // The space is 32 bytes, so the low 5 bits select the word.
    assign inSpace = (addr[11:5] == regBase[11:5]);
    assign offset  = regOffsetT'(addr[4:0]);
    assign byteEn  = {wr3, wr2, wr1, wr0};
    assign wrEn    = inSpace && (|byteEn);

    ///////////////////////////////////////////////////////////////////////
    // Readback
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        case (offset)
            regControl:   regWord = {28'h0, ctrl.clearAccum, ctrl.sweepEnable,
                                     ctrl.zeroError, ctrl.invertError};
            regGains:     regWord = {19'h0, ctrl.lagExp, 3'h0, ctrl.leadExp};
            regLimit:     regWord = ctrl.limit;
            regSweepRate: regWord = ctrl.sweepRate;
            regLock:      regWord = {4'h0, ctrl.syncThreshold, ctrl.lockCount};
            regLagAccum:  regWord = lagAccumTop;
            default:      regWord = 32'h0;
        endcase
    end

    assign dout       = inSpace ? regWord : 32'h0;
    assign mergedWord = mergeBytes(regWord, din, byteEn);

    ///////////////////////////////////////////////////////////////////////
    // Writes
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= '0;
        end else if (wrEn) begin
            case (offset)
                regControl: begin
                    ctrl.invertError <= mergedWord[0];
                    ctrl.zeroError   <= mergedWord[1];
                    ctrl.sweepEnable <= mergedWord[2];
                    ctrl.clearAccum  <= mergedWord[3];
                end
                regGains: begin
                    ctrl.leadExp <= mergedWord[4:0];
                    ctrl.lagExp  <= mergedWord[12:8];
                end
                regLimit:     ctrl.limit     <= mergedWord;
                regSweepRate: ctrl.sweepRate <= mergedWord;
                regLock: begin
                    ctrl.lockCount     <= mergedWord[15:0];
                    ctrl.syncThreshold <= mergedWord[27:16];
                end
                // Accumulator readback and unused offsets ignore writes.
                default: ;
            endcase
        end
    end

endmodule

// ==== runSim.sh ====
#!/bin/sh
# Compile and run the carrier loop testbench with Verilator.

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing -Wno-fatal --top-module carrierLoopTb \
    -f carrierLoop.f --Mdir "$buildDir"
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

"./$buildDir/VcarrierLoopTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "ERRORS FOUND" "$logFile"; then
    echo "Simulation failed, see $logFile"
    exit 1
fi
echo "Simulation passed"
exit 0

// ==== testbench/carrierLoopTb.sv ====
`timescale 1ns/10ps

module carrierLoopTb
    import carrierLoopPkg::*;
();

    localparam logic [11:0] regBase = 12'h100;
    localparam int clkPeriod = 4;
    localparam int resetCycles = 5;

    // Bus and strobe cycles of all tests plus margin for the watchdog.
    localparam int runCycles = resetCycles + 30 + 60 + 10 + 40 + 30 + 40;

    logic        clk = 1'b0;
    logic        reset;
    logic [11:0] addr;
    logic [31:0] din;
    logic        wr0;
    logic        wr1;
    logic        wr2;
    logic        wr3;
    demodModeT   demodMode;
    logic        ddcSync;
    logic        resampSync;
    logic [11:0] phase;
    logic [11:0] freq;
    logic        highFreqOffset;
    logic [11:0] offsetError;
    logic        offsetErrorEn;
    logic [31:0] dout;
    logic [31:0] carrierFreqOffset;
    logic [31:0] carrierLeadFreq;
    logic        carrierFreqEn;
    logic [11:0] loopError;
    logic        carrierLock;
    logic [15:0] lockCounter;

    // Reference model state.
    loopCtrlT    mCtrl;
    logic [11:0] mLoopError = 12'hx;
    logic [11:0] mAbs;
    longint      mLead;
    longint      mLag;
    logic        mSweepUp;
    logic [15:0] mCnt;
    logic        mLock;
    logic        fenSeen;

    logic [31:0] lcgState = 32'h59cf;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int testStartErrors = 0;

    carrierLoop #(.regBase(regBase)) DUT (.*);

    always #(clkPeriod / 2) clk = ~clk;

    initial begin
        #(4 * runCycles * clkPeriod);
        $display("Timeout: the tests stopped making progress");
        $display("ERRORS FOUND");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic checkWord(input logic [31:0] got, input logic [31:0] exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkError(input logic [11:0] got, input logic [11:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t loopError got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic checkLock(input logic gotLock, input logic [15:0] gotCnt,
                             input logic expLock, input logic [15:0] expCnt);
        checks++;
        if (gotLock !== expLock || gotCnt !== expCnt) begin
            errors++;
            $display("[ERROR] %0t carrierLock/lockCounter got %b/%h expected %b/%h",
                     $time, gotLock, gotCnt, expLock, expCnt);
        end
    endtask

    task automatic checkOut(input loopOutT got, input loopOutT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t loopOut got %h/%h/%b expected %h/%h/%b", $time,
                     got.freqOffset, got.leadFreq, got.freqEn,
                     exp.freqOffset, exp.leadFreq, exp.freqEn);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [11:0] lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[27:16];
    endfunction

    function automatic logic [31:0] regImage(loopCtrlT c, logic [4:0] off, longint lag);
        case (off)
            regControl:   return {28'h0, c.clearAccum, c.sweepEnable, c.zeroError, c.invertError};
            regGains:     return {19'h0, c.lagExp, 3'h0, c.leadExp};
            regLimit:     return c.limit;
            regSweepRate: return c.sweepRate;
            regLock:      return {4'h0, c.syncThreshold, c.lockCount};
            regLagAccum:  return 32'(lag >>> 8);
            default:      return 32'h0;
        endcase
    endfunction

    function automatic loopCtrlT applyWrite(loopCtrlT c, logic [4:0] off,
                                            logic [31:0] data, logic [3:0] be);
        logic [31:0] w;
        w = regImage(c, off, 0);
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                w[8*i +: 8] = data[8*i +: 8];
            end
        end
        case (off)
            regControl:   {c.clearAccum, c.sweepEnable, c.zeroError, c.invertError} = w[3:0];
            regGains: begin
                c.leadExp = w[4:0];
                c.lagExp  = w[12:8];
            end
            regLimit:     c.limit = w;
            regSweepRate: c.sweepRate = w;
            regLock: begin
                c.lockCount     = w[15:0];
                c.syncThreshold = w[27:16];
            end
            default: ;
        endcase
        return c;
    endfunction

    // Error, strobe and lock enable for the current inputs.
    function automatic void modeRule(output logic [11:0] err, output logic en,
                                     output logic lockEn);
        err = 12'h0;
        en = ddcSync;
        lockEn = 1'b1;
        case (demodMode)
            modeAm: lockEn = 1'b0;
            modePm: err = phase;
            modeFm, modePcmTrellis, modeMultiH: begin
                err = freq;
                lockEn = 1'b0;
            end
            mode2Fsk: begin
                err = offsetError;
                en = resampSync && offsetErrorEn;
                lockEn = 1'b0;
            end
            modeBpsk: err = (phase << 1) | 12'h1;
            modeQpsk, modeOqpsk, modeSoqpsk, modeAuqpsk: err = ((phase - 12'h200) << 2) | 12'h2;
            default: en = 1'b1;
        endcase
    endfunction

    // Advance the DUT and the model by one clock, then compare every output.
    task automatic step();
        logic [11:0] me;
        logic        en;
        logic        lockEn;
        logic [11:0] errNew;
        longint      errS;
        longint      lagStep;
        longint      sum;
        longint      lim;
        logic        sweeping;
        loopOutT     gotOut;
        loopOutT     expOut;
        #1;
        fenSeen = carrierFreqEn;
        modeRule(me, en, lockEn);
        if (mCtrl.zeroError || (mCtrl.sweepEnable && highFreqOffset)) begin
            errNew = 12'h0;
        end else if (mCtrl.invertError) begin
            errNew = 12'h0 - me;
        end else begin
            errNew = me;
        end
        @(posedge clk);
        @(negedge clk);
        sweeping = mCtrl.sweepEnable && !(mLock && !highFreqOffset);
        errS = longint'($signed(mLoopError));
        if (reset) begin
            mLead = 0;
            mLag = 0;
            mSweepUp = 1'b1;
        end else if (en) begin
            mLead = errS <<< mCtrl.leadExp;
            if (mCtrl.clearAccum) begin
                mLag = 0;
            end else begin
                lagStep = sweeping ? longint'(mCtrl.sweepRate) << 8 : errS <<< mCtrl.lagExp;
                if (sweeping && !mSweepUp) begin
                    lagStep = -lagStep;
                end
                sum = mLag + lagStep;
                lim = longint'(mCtrl.limit);
                if ((sum >>> 8) > lim) begin
                    mLag = lim <<< 8;
                    mSweepUp = sweeping ? 1'b0 : mSweepUp;
                end else if ((sum >>> 8) < -lim) begin
                    mLag = -(lim <<< 8);
                    mSweepUp = sweeping ? 1'b1 : mSweepUp;
                end else begin
                    mLag = sum;
                end
            end
        end
        if (reset || !lockEn) begin
            mCnt = 16'h0;
            mLock = 1'b1;
        end else if (en) begin
            if (mAbs > mCtrl.syncThreshold) begin
                if (mCnt == 16'hFFFF - mCtrl.lockCount) begin
                    mLock = 1'b0;
                    mCnt = 16'h0;
                end else begin
                    mCnt = mCnt - 16'h1;
                end
            end else if (mCnt == mCtrl.lockCount) begin
                mLock = 1'b1;
                mCnt = 16'h0;
            end else begin
                mCnt = mCnt + 16'h1;
            end
        end
        if (en) begin
            mLoopError = errNew;
            mAbs = me[11] ? 12'h0 - me : me;
        end
        if (reset) begin
            mCtrl = '0;
        end else if (addr[11:5] == regBase[11:5] && (wr0 || wr1 || wr2 || wr3)) begin
            mCtrl = applyWrite(mCtrl, addr[4:0], din, {wr3, wr2, wr1, wr0});
        end
        if (!$isunknown(mLoopError)) begin
            checkError(loopError, mLoopError);
        end
        gotOut.freqOffset = carrierFreqOffset;
        gotOut.leadFreq = carrierLeadFreq;
        gotOut.freqEn = fenSeen;
        expOut.freqOffset = 32'(mLag >>> 8);
        expOut.leadFreq = 32'(mLead >>> 8);
        expOut.freqEn = en;
        checkOut(gotOut, expOut);
        checkLock(carrierLock, lockCounter, mLock, mCnt);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bus and strobe drivers
    //////////////////////////////////////////////////////////////////////

    task automatic busWrite(input logic [11:0] a, input logic [31:0] data, input logic [3:0] be);
        addr = a;
        din = data;
        {wr3, wr2, wr1, wr0} = be;
        step();
        {wr3, wr2, wr1, wr0} = 4'h0;
    endtask

    task automatic writeReg(input regOffsetT off, input logic [31:0] data,
                            input logic [3:0] be = 4'hF);
        busWrite(regBase + 12'(off), data, be);
    endtask

    task automatic readReg(input regOffsetT off);
        addr = regBase + 12'(off);
        step();
        checkWord(dout, regImage(mCtrl, off, mLag), "dout");
    endtask

    task automatic randomizeInputs();
        phase = lcgNext();
        freq = lcgNext();
        offsetError = lcgNext();
    endtask

    task automatic strobe(input demodModeT mode, input logic useResamp = 1'b0);
        demodMode = mode;
        ddcSync = !useResamp;
        resampSync = useResamp;
        step();
        ddcSync = 1'b0;
        resampSync = 1'b0;
    endtask

    task automatic finishTest(input string name);
        tests++;
        $display("%s finished with %0d errors", name, errors - testStartErrors);
        testStartErrors = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic registerTest();
        readReg(regLagAccum);
        checkWord(dout, 32'h0, "dout");
        writeReg(regLimit, 32'h11223344);
        writeReg(regLimit, 32'hAABBCCDD, 4'b0101);
        readReg(regLimit);
        checkWord(dout, 32'h11BB33DD, "dout");
        writeReg(regGains, 32'hFFFFFFFF, 4'b0010);
        readReg(regGains);
        checkWord(dout, 32'h00001F00, "dout");
        writeReg(regLock, 32'hFFFFFFFF, 4'b1100);
        readReg(regLock);
        writeReg(regSweepRate, 32'h00000180, 4'b0011);
        readReg(regSweepRate);
        writeReg(regControl, 32'h0000000F, 4'b0001);
        readReg(regControl);
        writeReg(regLagAccum, 32'hFFFFFFFF);
        readReg(regLagAccum);
        // Neither a write nor a read outside the space reaches the registers.
        busWrite(regBase + 12'h020, 32'h55555555, 4'hF);
        checkWord(dout, 32'h0, "dout");
        busWrite(12'h000, 32'h0, 4'h0);
        checkWord(dout, 32'h0, "dout");
        readReg(regControl);
        finishTest("registerTest");
    endtask

    task automatic modeTest();
        logic [11:0] held;
        writeReg(regControl, 32'h0);
        writeReg(regGains, 32'h0);
        writeReg(regLimit, 32'h00010000);
        writeReg(regSweepRate, 32'h40);
        writeReg(regLock, {4'h0, 12'h100, 16'd3});
        for (int m = 0; m < 12; m++) begin
            randomizeInputs();
            strobe(demodModeT'(m));
            randomizeInputs();
            strobe(demodModeT'(m), 1'b1);
        end
        strobe(mode2Fsk, 1'b1);
        held = loopError;
        offsetErrorEn = 1'b0;
        randomizeInputs();
        strobe(mode2Fsk, 1'b1);
        checkError(loopError, held);
        offsetErrorEn = 1'b1;
        writeReg(regControl, 32'h1);
        randomizeInputs();
        strobe(modePm);
        checkError(loopError, 12'h0 - phase);
        writeReg(regControl, 32'h2);
        strobe(modePm);
        checkError(loopError, 12'h0);
        writeReg(regControl, 32'h4);
        highFreqOffset = 1'b1;
        strobe(modePm);
        checkError(loopError, 12'h0);
        highFreqOffset = 1'b0;
        writeReg(regControl, 32'h0);
        finishTest("modeTest");
    endtask

    task automatic leadTest();
        writeReg(regGains, 32'h0000000A);
        phase = 12'h123;
        strobe(modePm);
        strobe(modePm);
        checkWord(carrierLeadFreq, 32'h0000048C, "carrierLeadFreq");
        phase = 12'hF00;
        strobe(modePm);
        strobe(modePm);
        checkWord(carrierLeadFreq, 32'hFFFFFC00, "carrierLeadFreq");
        finishTest("leadTest");
    endtask

    task automatic lagTest();
        phase = 12'h010;
        writeReg(regControl, 32'h8);
        strobe(modePm);
        checkWord(carrierFreqOffset, 32'h0, "carrierFreqOffset");
        writeReg(regControl, 32'h0);
        writeReg(regGains, 32'h00000C00);
        writeReg(regLimit, 32'h00001000);
        repeat (24) strobe(modePm);
        checkWord(carrierFreqOffset, 32'h00001000, "carrierFreqOffset");
        writeReg(regControl, 32'h8);
        strobe(modePm);
        checkWord(carrierFreqOffset, 32'h0, "carrierFreqOffset");
        writeReg(regControl, 32'h0);
        finishTest("lagTest");
    endtask

    task automatic lockTest();
        writeReg(regLock, {4'h0, 12'h080, 16'd4});
        freq = 12'h000;
        strobe(modeFm);
        phase = 12'h010;
        repeat (6) strobe(modeBpsk);
        // Lock was reached after four quiet strobes and the counter restarted.
        checkLock(carrierLock, lockCounter, 1'b1, 16'h0001);
        phase = 12'h100;
        repeat (12) strobe(modeBpsk);
        checkLock(carrierLock, lockCounter, 1'b0, 16'hFFFD);
        strobe(modeFm);
        checkLock(carrierLock, lockCounter, 1'b1, 16'h0);
        finishTest("lockTest");
    endtask

    task automatic sweepTest();
        longint maxSeen;
        longint minSeen;
        phase = 12'h100;
        repeat (12) strobe(modeBpsk);
        writeReg(regLimit, 32'h00000400);
        writeReg(regSweepRate, 32'h00000100);
        writeReg(regControl, 32'h8);
        strobe(modeBpsk);
        writeReg(regControl, 32'h4);
        maxSeen = 0;
        minSeen = 0;
        repeat (20) begin
            strobe(modeBpsk);
            maxSeen = longint'($signed(carrierFreqOffset)) > maxSeen ?
                      longint'($signed(carrierFreqOffset)) : maxSeen;
            minSeen = longint'($signed(carrierFreqOffset)) < minSeen ?
                      longint'($signed(carrierFreqOffset)) : minSeen;
        end
        checkWord(32'(maxSeen), 32'h00000400, "carrierFreqOffset maximum");
        checkWord(32'(minSeen), 32'hFFFFFC00, "carrierFreqOffset minimum");
        writeReg(regControl, 32'h0);
        finishTest("sweepTest");
    endtask

    initial begin
        reset = 1'b1;
        addr = 12'h0;
        din = 32'h0;
        {wr3, wr2, wr1, wr0} = 4'h0;
        demodMode = modeAm;
        // Strobes during reset give loopError a known value.
        ddcSync = 1'b1;
        resampSync = 1'b0;
        phase = 12'h0;
        freq = 12'h0;
        highFreqOffset = 1'b0;
        offsetError = 12'h0;
        offsetErrorEn = 1'b1;
        repeat (resetCycles) step();
        reset = 1'b0;
        ddcSync = 1'b0;
        registerTest();
        modeTest();
        leadTest();
        lagTest();
        lockTest();
        sweepTest();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
